//--- rtl/cs_marker_pkg.sv
// JPEG 2000 codestream content
// marker codes, fixed segment bytes and segment lengths used by the
// header generators, the byte counter and the testbench model

`default_nettype none

package cs_marker_pkg;

    // ----------------------------------------
    // markers
    // ----------------------------------------
    localparam logic [15:0] MRK_SOC = 16'hFF4F;
    localparam logic [15:0] MRK_SIZ = 16'hFF51;
    localparam logic [15:0] MRK_COD = 16'hFF52;
    localparam logic [15:0] MRK_QCD = 16'hFF5C;
    localparam logic [15:0] MRK_SOT = 16'hFF90;
    localparam logic [15:0] MRK_SOD = 16'hFF93;
    localparam logic [15:0] MRK_EOC = 16'hFFD9;

    // ----------------------------------------
    // segment lengths (marker not counted)
    // ----------------------------------------
    localparam logic [15:0] SIZ_FIXED_LEN = 16'd38;  // plus 3 per component
    localparam logic [15:0] COD_LEN       = 16'd12;
    localparam logic [15:0] QCD_LEN       = 16'd11;
    localparam logic [15:0] SOT_LEN       = 16'd10;

    // SOT segment plus SOD marker, counted in Psot
    localparam logic [31:0] TP_OVERHEAD   = 32'd14;

    // ----------------------------------------
    // fixed field values
    // ----------------------------------------
    localparam logic [7:0]  COMP_SSIZ         = 8'h07;     // 8-bit unsigned
    localparam logic [7:0]  QCD_SQCD          = 8'h42;     // expounded, 2 guard bits
    localparam logic [15:0] QCD_SUBBAND       = 16'h5000;  // exponent 10, mantissa 0
    localparam logic [7:0]  COD_DECOMP_LEVELS = 8'd1;
    localparam logic [7:0]  COD_CB_EXP        = 8'd4;      // width and height
    localparam logic [7:0]  COD_XFORM         = 8'h01;     // reversible 5/3

endpackage

`default_nettype wire

//--- rtl/asm_ctrl_pkg.sv
// codestream assembler control types
// sequencer states, output byte sources and counter widths

`default_nettype none

package asm_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MAIN,   // main header bytes
        ST_TPHDR,  // SOT segment and SOD marker
        ST_BODY,   // tile-part body pass-through
        ST_EOC
    } seq_state_t;

    typedef enum logic [1:0] {
        SRC_MAIN,
        SRC_TP,
        SRC_BODY,
        SRC_EOC
    } byte_src_t;

    localparam int IDX_W = 7;   // covers the 78-byte main header
    localparam int LEN_W = 16;  // body length and body count
    localparam int TP_W  = 8;   // tile-part index

endpackage

`default_nettype wire

//--- rtl/cs_sequencer.sv
// codestream sequencer
// steps main header, tile-part headers and bodies, then EOC, and
// decides when a byte may be placed in the output stage

`timescale 1ns/1ps
`default_nettype none

module cs_sequencer (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire                        tp_len_valid_i,
    input  wire                        s_data_valid_i,
    input  wire                        take_i,
    input  wire                        seg_last_i,
    input  wire                        tp_last_i,
    output asm_ctrl_pkg::seq_state_t   state_o,
    output asm_ctrl_pkg::byte_src_t    src_o,
    output logic                       advance_o,
    output logic                       tp_len_ready_o,
    output logic                       s_data_ready_o,
    output logic                       busy_o
);

    asm_ctrl_pkg::seq_state_t state_q;
    logic                     len_ok_q;    // tile-part length accepted
    logic                     eoc_done_q;  // final byte sits in the output stage

    assign state_o = state_q;

    always_comb begin
        src_o          = asm_ctrl_pkg::SRC_MAIN;
        advance_o      = 1'b0;
        tp_len_ready_o = 1'b0;
        s_data_ready_o = 1'b0;
        case (state_q)
            asm_ctrl_pkg::ST_MAIN: begin
                advance_o = take_i;
            end
            asm_ctrl_pkg::ST_TPHDR: begin
                src_o          = asm_ctrl_pkg::SRC_TP;
                tp_len_ready_o = take_i && !len_ok_q;  // length before first SOT byte
                advance_o      = take_i && len_ok_q;
            end
            asm_ctrl_pkg::ST_BODY: begin
                src_o          = asm_ctrl_pkg::SRC_BODY;
                s_data_ready_o = take_i;
                advance_o      = take_i && s_data_valid_i;
            end
            asm_ctrl_pkg::ST_EOC: begin
                src_o     = asm_ctrl_pkg::SRC_EOC;
                advance_o = take_i && !eoc_done_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= asm_ctrl_pkg::ST_IDLE;
            len_ok_q   <= 1'b0;
            eoc_done_q <= 1'b0;
            busy_o     <= 1'b0;
        end else begin
            case (state_q)
                asm_ctrl_pkg::ST_IDLE: begin
                    if (start_i) begin
                        state_q <= asm_ctrl_pkg::ST_MAIN;
                        busy_o  <= 1'b1;
                    end
                end
                asm_ctrl_pkg::ST_MAIN: begin
                    if (advance_o && seg_last_i) begin
                        state_q <= asm_ctrl_pkg::ST_TPHDR;
                    end
                end
                asm_ctrl_pkg::ST_TPHDR: begin
                    if (tp_len_ready_o && tp_len_valid_i) begin
                        len_ok_q <= 1'b1;
                    end
                    if (advance_o && seg_last_i) begin  // SOD low byte loaded
                        state_q  <= asm_ctrl_pkg::ST_BODY;
                        len_ok_q <= 1'b0;
                    end
                end
                asm_ctrl_pkg::ST_BODY: begin
                    if (advance_o && seg_last_i) begin
                        state_q <= tp_last_i ? asm_ctrl_pkg::ST_EOC : asm_ctrl_pkg::ST_TPHDR;
                    end
                end
                asm_ctrl_pkg::ST_EOC: begin
                    // register was just loaded, so take here means the sink took it
                    if (eoc_done_q && take_i) begin
                        state_q    <= asm_ctrl_pkg::ST_IDLE;
                        eoc_done_q <= 1'b0;
                        busy_o     <= 1'b0;
                    end else if (advance_o && seg_last_i) begin
                        eoc_done_q <= 1'b1;
                    end
                end
                default: state_q <= asm_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    state_enc_a: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {asm_ctrl_pkg::ST_IDLE, asm_ctrl_pkg::ST_MAIN, asm_ctrl_pkg::ST_TPHDR,
                        asm_ctrl_pkg::ST_BODY, asm_ctrl_pkg::ST_EOC})
        else $error("sequencer state outside its encoding");

endmodule

`default_nettype wire

//--- rtl/byte_counter.sv
// segment byte counter
// counts bytes of the current segment, latches the tile-part body
// length and keeps the tile-part index

`timescale 1ns/1ps
`default_nettype none

module byte_counter #(
    parameter int NUM_COMP       = 3,
    parameter int NUM_TILE_PARTS = 2
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire asm_ctrl_pkg::seq_state_t    state_i,
    input  wire                              advance_i,
    input  wire [asm_ctrl_pkg::LEN_W-1:0]    tp_len_i,
    input  wire                              tp_len_valid_i,
    input  wire                              tp_len_ready_i,
    output logic [asm_ctrl_pkg::IDX_W-1:0]   hdr_idx_o,
    output logic [asm_ctrl_pkg::LEN_W-1:0]   body_len_o,
    output logic [asm_ctrl_pkg::TP_W-1:0]    tp_idx_o,
    output logic                             seg_last_o,
    output logic                             tp_last_o
);

    // four markers plus the SIZ, COD and QCD segments
    localparam logic [asm_ctrl_pkg::LEN_W-1:0] MAIN_LEN = 16'd8 + cs_marker_pkg::SIZ_FIXED_LEN
        + 16'(3 * NUM_COMP) + cs_marker_pkg::COD_LEN + cs_marker_pkg::QCD_LEN;
    localparam logic [asm_ctrl_pkg::LEN_W-1:0] TP_HDR_LEN = cs_marker_pkg::SOT_LEN + 16'd4;

    logic [asm_ctrl_pkg::LEN_W-1:0] cnt_q;
    logic [asm_ctrl_pkg::LEN_W-1:0] seg_len;
    logic                           len_xfer;

    assign len_xfer = tp_len_valid_i && tp_len_ready_i;

    always_comb begin
        case (state_i)
            asm_ctrl_pkg::ST_TPHDR: seg_len = TP_HDR_LEN;
            asm_ctrl_pkg::ST_BODY:  seg_len = body_len_o;
            asm_ctrl_pkg::ST_EOC:   seg_len = 16'd2;
            default:                seg_len = MAIN_LEN;
        endcase
    end

    assign seg_last_o = (cnt_q == seg_len - 1'b1);
    assign hdr_idx_o  = cnt_q[asm_ctrl_pkg::IDX_W-1:0];
    assign tp_last_o  = (int'(tp_idx_o) == NUM_TILE_PARTS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q    <= '0;
            tp_idx_o <= '0;
        end else if (state_i == asm_ctrl_pkg::ST_IDLE) begin
            cnt_q    <= '0;  // fresh codestream
            tp_idx_o <= '0;
        end else if (advance_i) begin
            cnt_q <= seg_last_o ? '0 : cnt_q + 1'b1;
            if (seg_last_o && state_i == asm_ctrl_pkg::ST_BODY) begin
                tp_idx_o <= tp_idx_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (len_xfer) begin
            body_len_o <= tp_len_i;
        end
    end

    len_nonzero_a: assert property (@(posedge clk) disable iff (!rst_n)
        len_xfer |-> tp_len_i != '0)
        else $error("zero tile-part body length accepted");

endmodule

`default_nettype wire

//--- rtl/main_hdr_rom.sv
// main header byte lookup
// SOC, SIZ, COD and QCD laid out big-endian from the image parameters

`timescale 1ns/1ps
`default_nettype none

module main_hdr_rom #(
    parameter logic [31:0] IMG_WIDTH  = 32'd128,
    parameter logic [31:0] IMG_HEIGHT = 32'd128,
    parameter int          NUM_COMP   = 3
) (
    input  wire [asm_ctrl_pkg::IDX_W-1:0] hdr_idx_i,
    output logic [7:0]                    byte_o
);

    localparam int HDR_LEN = 69 + 3 * NUM_COMP;

    // ----------------------------------------
    // header image, first byte in the top bits
    // ----------------------------------------
    localparam logic [8*HDR_LEN-1:0] HDR = {
        cs_marker_pkg::MRK_SOC,
        // SIZ
        cs_marker_pkg::MRK_SIZ,
        cs_marker_pkg::SIZ_FIXED_LEN + 16'(3 * NUM_COMP),
        16'h0000,                 // Rsiz
        IMG_WIDTH,
        IMG_HEIGHT,
        64'h0,                    // image offsets
        IMG_WIDTH,                // single tile covers the image
        IMG_HEIGHT,
        64'h0,                    // tile offsets
        16'(NUM_COMP),
        {NUM_COMP{cs_marker_pkg::COMP_SSIZ, 8'h01, 8'h01}},
        // COD
        cs_marker_pkg::MRK_COD,
        cs_marker_pkg::COD_LEN,
        8'h00,                    // Scod
        8'h00,                    // LRCP
        16'h0001,                 // one layer
        (NUM_COMP == 3) ? 8'h01 : 8'h00,
        cs_marker_pkg::COD_DECOMP_LEVELS,
        cs_marker_pkg::COD_CB_EXP,
        cs_marker_pkg::COD_CB_EXP,
        8'h00,                    // code-block style
        cs_marker_pkg::COD_XFORM,
        // QCD
        cs_marker_pkg::MRK_QCD,
        cs_marker_pkg::QCD_LEN,
        cs_marker_pkg::QCD_SQCD,
        {4{cs_marker_pkg::QCD_SUBBAND}}  // LL, HL, LH, HH
    };

    always_comb begin
        if (int'(hdr_idx_i) < HDR_LEN) begin
            byte_o = HDR[8*(HDR_LEN-1-int'(hdr_idx_i)) +: 8];
        end else begin
            byte_o = 8'h00;  // past the end
        end
    end

endmodule

`default_nettype wire

//--- rtl/tile_part_hdr_gen.sv
// tile-part header byte lookup
// SOT segment of the current tile part followed by the SOD marker

`timescale 1ns/1ps
`default_nettype none

module tile_part_hdr_gen #(
    parameter int NUM_TILE_PARTS = 2
) (
    input  wire [asm_ctrl_pkg::IDX_W-1:0] hdr_idx_i,
    input  wire [asm_ctrl_pkg::TP_W-1:0]  tp_idx_i,
    input  wire [asm_ctrl_pkg::LEN_W-1:0] body_len_i,
    output logic [7:0]                    byte_o
);

    logic [31:0] psot;

    assign psot = cs_marker_pkg::TP_OVERHEAD + 32'(body_len_i);

    always_comb begin
        case (hdr_idx_i)
            7'd0:    byte_o = cs_marker_pkg::MRK_SOT[15:8];
            7'd1:    byte_o = cs_marker_pkg::MRK_SOT[7:0];
            7'd2:    byte_o = cs_marker_pkg::SOT_LEN[15:8];
            7'd3:    byte_o = cs_marker_pkg::SOT_LEN[7:0];
            7'd4,
            7'd5:    byte_o = 8'h00;         // Isot, single tile
            7'd6:    byte_o = psot[31:24];
            7'd7:    byte_o = psot[23:16];
            7'd8:    byte_o = psot[15:8];
            7'd9:    byte_o = psot[7:0];
            7'd10:   byte_o = tp_idx_i;      // TPsot
            7'd11:   byte_o = 8'(NUM_TILE_PARTS);
            7'd12:   byte_o = cs_marker_pkg::MRK_SOD[15:8];
            7'd13:   byte_o = cs_marker_pkg::MRK_SOD[7:0];
            default: byte_o = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/byte_out_stage.sv
// output byte register
// picks the byte source, holds it under back-pressure and flags
// the final EOC byte as last

`timescale 1ns/1ps
`default_nettype none

module byte_out_stage (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           load_i,
    input  wire asm_ctrl_pkg::byte_src_t  src_i,
    input  wire [7:0]                     main_byte_i,
    input  wire [7:0]                     tp_byte_i,
    input  wire [7:0]                     body_byte_i,
    input  wire                           m_ready_i,
    output logic                          take_o,
    output logic [7:0]                    m_data_o,
    output logic                          m_valid_o,
    output logic                          m_last_o
);

    logic [7:0] next_byte;
    logic       eoc_lo_q;   // low bit of the EOC byte index

    // empty, or being emptied this cycle
    assign take_o = !m_valid_o || m_ready_i;

    always_comb begin
        case (src_i)
            asm_ctrl_pkg::SRC_MAIN: next_byte = main_byte_i;
            asm_ctrl_pkg::SRC_TP:   next_byte = tp_byte_i;
            asm_ctrl_pkg::SRC_BODY: next_byte = body_byte_i;
            default: begin
                next_byte = eoc_lo_q ? cs_marker_pkg::MRK_EOC[7:0]
                                     : cs_marker_pkg::MRK_EOC[15:8];
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid_o <= 1'b0;
            m_last_o  <= 1'b0;
            eoc_lo_q  <= 1'b0;
        end else if (load_i) begin
            m_valid_o <= 1'b1;
            m_last_o  <= (src_i == asm_ctrl_pkg::SRC_EOC) && eoc_lo_q;
            if (src_i == asm_ctrl_pkg::SRC_EOC) begin
                eoc_lo_q <= !eoc_lo_q;
            end
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
            m_last_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            m_data_o <= next_byte;
        end
    end

    out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid_o && !m_ready_i |=> $stable(m_data_o) && $stable(m_last_o))
        else $error("output byte changed under back-pressure");

endmodule

`default_nettype wire

//--- rtl/jp2_asm_top.sv
// JPEG 2000 codestream assembler top level
// main header, tile parts with pass-through bodies, then EOC,
// emitted one byte at a time over a valid/ready stream

`timescale 1ns/1ps
`default_nettype none

module jp2_asm_top #(
    parameter logic [31:0] IMG_WIDTH      = 32'd128,
    parameter logic [31:0] IMG_HEIGHT     = 32'd128,
    parameter int          NUM_COMP       = 3,
    parameter int          NUM_TILE_PARTS = 2
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start_i,
    output logic                          busy_o,
    input  wire [asm_ctrl_pkg::LEN_W-1:0] tp_len_i,
    input  wire                           tp_len_valid_i,
    output logic                          tp_len_ready_o,
    input  wire [7:0]                     s_data_i,
    input  wire                           s_data_valid_i,
    output logic                          s_data_ready_o,
    output logic [7:0]                    m_data_o,
    output logic                          m_last_o,
    output logic                          m_valid_o,
    input  wire                           m_ready_i
);

    asm_ctrl_pkg::seq_state_t       state;
    asm_ctrl_pkg::byte_src_t        src;
    logic                           advance;
    logic                           take;
    logic                           seg_last;
    logic                           tp_last;
    logic [asm_ctrl_pkg::IDX_W-1:0] hdr_idx;
    logic [asm_ctrl_pkg::LEN_W-1:0] body_len;
    logic [asm_ctrl_pkg::TP_W-1:0]  tp_idx;
    logic [7:0]                     main_byte;
    logic [7:0]                     tp_byte;

    cs_sequencer cs_sequencer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .tp_len_valid_i (tp_len_valid_i),
        .s_data_valid_i (s_data_valid_i),
        .take_i         (take),
        .seg_last_i     (seg_last),
        .tp_last_i      (tp_last),
        .state_o        (state),
        .src_o          (src),
        .advance_o      (advance),
        .tp_len_ready_o (tp_len_ready_o),
        .s_data_ready_o (s_data_ready_o),
        .busy_o         (busy_o)
    );

    byte_counter #(
        .NUM_COMP       (NUM_COMP),
        .NUM_TILE_PARTS (NUM_TILE_PARTS)
    ) byte_counter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .state_i        (state),
        .advance_i      (advance),
        .tp_len_i       (tp_len_i),
        .tp_len_valid_i (tp_len_valid_i),
        .tp_len_ready_i (tp_len_ready_o),
        .hdr_idx_o      (hdr_idx),
        .body_len_o     (body_len),
        .tp_idx_o       (tp_idx),
        .seg_last_o     (seg_last),
        .tp_last_o      (tp_last)
    );

    main_hdr_rom #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .NUM_COMP   (NUM_COMP)
    ) main_hdr_rom_inst (
        .hdr_idx_i (hdr_idx),
        .byte_o    (main_byte)
    );

    tile_part_hdr_gen #(
        .NUM_TILE_PARTS (NUM_TILE_PARTS)
    ) tile_part_hdr_gen_inst (
        .hdr_idx_i  (hdr_idx),
        .tp_idx_i   (tp_idx),
        .body_len_i (body_len),
        .byte_o     (tp_byte)
    );

    // body bytes go straight into the output register
    byte_out_stage byte_out_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (advance),
        .src_i       (src),
        .main_byte_i (main_byte),
        .tp_byte_i   (tp_byte),
        .body_byte_i (s_data_i),
        .m_ready_i   (m_ready_i),
        .take_o      (take),
        .m_data_o    (m_data_o),
        .m_valid_o   (m_valid_o),
        .m_last_o    (m_last_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// testbench clock and reset
// free-running clock, reset held low for a few cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_n_o = 1'b1;  // released with the other inputs
    end

endmodule

`default_nettype wire

//--- dv/tb_jp2_asm.sv
// testbench for the JPEG 2000 codestream assembler
// directed runs against a byte-level codestream model, with
// back-pressure, delayed lengths and gapped body input

`timescale 1ns/1ps
`default_nettype none

module tb_jp2_asm;

    localparam logic [31:0] IMG_WIDTH  = 32'd128;
    localparam logic [31:0] IMG_HEIGHT = 32'd128;
    localparam int          NUM_COMP   = 3;
    localparam int          NUM_TP     = 2;
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] SEED       = 32'h951ceeef;

    logic                           clk;
    logic                           rst_n;
    logic                           start_i;
    logic                           busy_o;
    logic [asm_ctrl_pkg::LEN_W-1:0] tp_len_i;
    logic                           tp_len_valid_i;
    logic                           tp_len_ready_o;
    logic [7:0]                     s_data_i;
    logic                           s_data_valid_i;
    logic                           s_data_ready_o;
    logic [7:0]                     m_data_o;
    logic                           m_last_o;
    logic                           m_valid_o;
    logic                           m_ready_i;

    // ----------------------------------------
    // run data and bookkeeping
    // ----------------------------------------
    logic [15:0] run_lens [NUM_TP];  // body lengths of the current run
    logic [7:0]  run_body [$];       // all body bytes, tile parts back to back
    logic [15:0] lens_fix [NUM_TP];
    logic [15:0] lens_a [NUM_TP];
    logic [15:0] lens_b [NUM_TP];
    logic [7:0]  body_fix [$];
    logic [7:0]  body_a [$];
    logic [7:0]  body_b [$];
    logic [7:0]  exp_q [$];
    bit          stall_en;
    bit          gap_en;
    bit          run_done;
    int          first_valid_cyc;
    int          stall_hits;         // cycles with a held output byte
    int          cyc = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    longint      wd_cycles;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) tb_clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    jp2_asm_top #(
        .IMG_WIDTH      (IMG_WIDTH),
        .IMG_HEIGHT     (IMG_HEIGHT),
        .NUM_COMP       (NUM_COMP),
        .NUM_TILE_PARTS (NUM_TP)
    ) jp2_asm_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .busy_o         (busy_o),
        .tp_len_i       (tp_len_i),
        .tp_len_valid_i (tp_len_valid_i),
        .tp_len_ready_o (tp_len_ready_o),
        .s_data_i       (s_data_i),
        .s_data_valid_i (s_data_valid_i),
        .s_data_ready_o (s_data_ready_o),
        .m_data_o       (m_data_o),
        .m_last_o       (m_last_o),
        .m_valid_o      (m_valid_o),
        .m_ready_i      (m_ready_i)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic log_error(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ----------------------------------------
    // codestream model
    // ----------------------------------------
    task automatic push_bytes(input logic [31:0] value, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back(value[8*i +: 8]);  // big-endian
        end
    endtask

    task automatic build_expected;
        int pos;
        exp_q.delete();
        pos = 0;
        push_bytes(cs_marker_pkg::MRK_SOC, 2);
        push_bytes(cs_marker_pkg::MRK_SIZ, 2);
        push_bytes(cs_marker_pkg::SIZ_FIXED_LEN + 3 * NUM_COMP, 2);
        push_bytes(0, 2);                       // Rsiz
        push_bytes(IMG_WIDTH, 4);
        push_bytes(IMG_HEIGHT, 4);
        repeat (2) push_bytes(0, 4);            // image offsets
        push_bytes(IMG_WIDTH, 4);               // one tile, image sized
        push_bytes(IMG_HEIGHT, 4);
        repeat (2) push_bytes(0, 4);
        push_bytes(NUM_COMP, 2);
        repeat (NUM_COMP) push_bytes({cs_marker_pkg::COMP_SSIZ, 8'h01, 8'h01}, 3);
        push_bytes(cs_marker_pkg::MRK_COD, 2);
        push_bytes(cs_marker_pkg::COD_LEN, 2);
        push_bytes(0, 2);                       // Scod, progression
        push_bytes(1, 2);                       // layers
        push_bytes((NUM_COMP == 3) ? 1 : 0, 1);
        push_bytes(cs_marker_pkg::COD_DECOMP_LEVELS, 1);
        push_bytes({cs_marker_pkg::COD_CB_EXP, cs_marker_pkg::COD_CB_EXP}, 2);
        push_bytes(0, 1);
        push_bytes(cs_marker_pkg::COD_XFORM, 1);
        push_bytes(cs_marker_pkg::MRK_QCD, 2);
        push_bytes(cs_marker_pkg::QCD_LEN, 2);
        push_bytes(cs_marker_pkg::QCD_SQCD, 1);
        repeat (4) push_bytes(cs_marker_pkg::QCD_SUBBAND, 2);
        for (int tp = 0; tp < NUM_TP; tp++) begin
            push_bytes(cs_marker_pkg::MRK_SOT, 2);
            push_bytes(cs_marker_pkg::SOT_LEN, 2);
            push_bytes(0, 2);                   // Isot
            push_bytes(cs_marker_pkg::TP_OVERHEAD + run_lens[tp], 4);
            push_bytes(tp, 1);
            push_bytes(NUM_TP, 1);
            push_bytes(cs_marker_pkg::MRK_SOD, 2);
            for (int i = 0; i < run_lens[tp]; i++) begin
                exp_q.push_back(run_body[pos]);
                pos++;
            end
        end
        push_bytes(cs_marker_pkg::MRK_EOC, 2);
    endtask

    task automatic randomize_run;
        run_body.delete();
        for (int tp = 0; tp < NUM_TP; tp++) begin
            run_lens[tp] = 16'(1 + $urandom % 40);
            repeat (run_lens[tp]) run_body.push_back(8'($urandom % 256));
        end
    endtask

    // ----------------------------------------
    // channel drivers and output monitor
    // ----------------------------------------
    task automatic drive_lengths;
        for (int tp = 0; tp < NUM_TP; tp++) begin
            if (gap_en) repeat ($urandom % 12) next_cycle();
            tp_len_i       = run_lens[tp];
            tp_len_valid_i = 1'b1;
            do @(negedge clk); while (!tp_len_ready_o);
            next_cycle();
            tp_len_valid_i = 1'b0;
        end
    endtask

    task automatic drive_body;
        foreach (run_body[i]) begin
            if (gap_en && ($urandom % 3 == 0)) repeat (1 + $urandom % 4) next_cycle();
            s_data_i       = run_body[i];
            s_data_valid_i = 1'b1;
            do @(negedge clk); while (!s_data_ready_o);
            next_cycle();
            s_data_valid_i = 1'b0;
        end
    endtask

    task automatic drive_ready;
        while (!run_done) begin
            next_cycle();
            m_ready_i = stall_en ? ($urandom % 3 != 0) : 1'b1;
        end
        m_ready_i = 1'b1;
    endtask

    task automatic collect_stream;
        int idx;
        idx = 0;
        while (!run_done) begin
            @(negedge clk);  // inputs and outputs settled here
            if (m_valid_o && first_valid_cyc < 0) first_valid_cyc = cyc;
            if (m_valid_o && !m_ready_i) begin
                stall_hits++;
                // held byte, so no input may be accepted
                if (tp_len_ready_o !== 1'b0) begin
                    log_error($sformatf("mismatch at %0t: tp_len_ready_o expected 0 actual %b",
                        $time, tp_len_ready_o));
                end
                if (s_data_ready_o !== 1'b0) begin
                    log_error($sformatf("mismatch at %0t: s_data_ready_o expected 0 actual %b",
                        $time, s_data_ready_o));
                end
            end
            if (m_valid_o && m_ready_i) begin
                if (m_data_o !== exp_q[idx]) begin
                    log_error($sformatf(
                        "mismatch at %0t: m_data_o byte %0d expected 8'h%02h actual 8'h%02h",
                        $time, idx, exp_q[idx], m_data_o));
                end
                if (m_last_o && idx != exp_q.size() - 1) begin
                    log_error($sformatf("m_last_o came early on byte %0d at %0t", idx, $time));
                end
                if (!m_last_o && idx == exp_q.size() - 1) begin
                    log_error($sformatf("final byte at %0t was taken without m_last_o", $time));
                end
                idx++;
                if (m_last_o || idx == exp_q.size()) run_done = 1'b1;
            end
        end
        if (idx < exp_q.size()) begin
            log_error($sformatf("stream ended after %0d of %0d bytes", idx, exp_q.size()));
        end
        next_cycle();  // final transfer edge
        if (busy_o) log_error("busy_o still high after the last transfer");
    endtask

    task automatic run_stream(input bit stall, input bit gaps);
        int  start_cyc;
        bit  stray;
        stall_en        = stall;
        gap_en          = gaps;
        run_done        = 1'b0;
        first_valid_cyc = -1;
        stall_hits      = 0;
        stray           = 1'b0;
        build_expected();
        start_i = 1'b1;
        next_cycle();
        start_i   = 1'b0;
        start_cyc = cyc;
        if (!busy_o) log_error("busy_o did not rise after start_i");
        fork
            drive_lengths();
            drive_body();
            drive_ready();
            collect_stream();
        join
        if (first_valid_cyc != start_cyc + 1) begin
            log_error($sformatf("first byte valid in cycle %0d, expected cycle %0d",
                first_valid_cyc, start_cyc + 1));
        end
        repeat (8) begin
            @(negedge clk);
            if (m_valid_o) stray = 1'b1;
        end
        if (stray) log_error("stray byte presented after the end of the codestream");
        next_cycle();
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_idle_outputs;
        int errs;
        bit bad;
        errs = err_cnt;
        bad  = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (m_valid_o || busy_o || tp_len_ready_o || s_data_ready_o) bad = 1'b1;
        end
        if (bad) log_error("outputs left their reset values while idle without start_i");
        next_cycle();
        end_test("idle after reset", errs);
    endtask

    task automatic test_main_header;
        int errs;
        errs     = err_cnt;
        run_lens = lens_fix;
        run_body = body_fix;
        run_stream(1'b0, 1'b0);
        end_test("main header", errs);
    endtask

    task automatic test_random_run;
        int errs;
        errs     = err_cnt;
        run_lens = lens_a;
        run_body = body_a;
        run_stream(1'b0, 1'b0);
        end_test("random tile parts", errs);
    endtask

    task automatic test_back_pressure;
        int errs;
        errs     = err_cnt;
        run_lens = lens_a;
        run_body = body_a;
        run_stream(1'b1, 1'b0);
        if (stall_hits == 0) log_error("no stall cycle landed on a valid output byte");
        end_test("back-pressure", errs);
    endtask

    task automatic test_gapped_inputs;
        int errs;
        errs     = err_cnt;
        run_lens = lens_b;
        run_body = body_b;
        run_stream(1'b0, 1'b1);
        end_test("delayed length, gapped body", errs);
    endtask

    initial begin
        start_i        = 1'b0;
        tp_len_i       = '0;
        tp_len_valid_i = 1'b0;
        s_data_i       = 8'h00;
        s_data_valid_i = 1'b0;
        m_ready_i      = 1'b1;
        void'($urandom(SEED));

        lens_fix[0] = 16'd3;
        lens_fix[1] = 16'd5;
        for (int i = 0; i < 8; i++) body_fix.push_back(8'(i * 37 + 5));
        randomize_run();
        lens_a = run_lens;
        body_a = run_body;
        randomize_run();
        lens_b = run_lens;
        body_b = run_body;

        // watchdog budget from the model's byte counts, set a runs twice
        run_lens = lens_fix;
        run_body = body_fix;
        build_expected();
        wd_cycles = exp_q.size();
        run_lens = lens_a;
        run_body = body_a;
        build_expected();
        wd_cycles += 2 * exp_q.size();
        run_lens = lens_b;
        run_body = body_b;
        build_expected();
        wd_cycles = 200 * (wd_cycles + exp_q.size());
        fork
            begin
                #(wd_cycles * CLK_PERIOD);
                $display("watchdog expired at %0t, the DUT stopped making progress", $time);
                $display("Simulation failed");
                $finish;
            end
        join_none

        @(posedge rst_n);
        next_cycle();
        test_idle_outputs();
        test_main_header();
        test_random_run();
        test_back_pressure();
        test_gapped_inputs();

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/cs_marker_pkg.sv
rtl/asm_ctrl_pkg.sv
rtl/cs_sequencer.sv
rtl/byte_counter.sv
rtl/main_hdr_rom.sv
rtl/tile_part_hdr_gen.sv
rtl/byte_out_stage.sv
rtl/jp2_asm_top.sv
dv/tb_clk_gen.sv
dv/tb_jp2_asm.sv

//--- Bender.yml
package:
  name: jp2_asm

sources:
  - files:
      - rtl/cs_marker_pkg.sv
      - rtl/asm_ctrl_pkg.sv
      - rtl/cs_sequencer.sv
      - rtl/byte_counter.sv
      - rtl/main_hdr_rom.sv
      - rtl/tile_part_hdr_gen.sv
      - rtl/byte_out_stage.sv
      - rtl/jp2_asm_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_jp2_asm.sv
